//--- bench/exu_tb_cases.svh
// one entry per row, indexed together
string     name_q[$];
dec_grp_t  grp_q[$];
dec_op_t   op_q[$];
logic      imm_sel_q[$];
pc_t       pc_q[$];
xlen_t     imm_q[$];
xlen_t     rs1_q[$];
xlen_t     rs2_q[$];
reg_addr_t rd_q[$];
xlen_t     res_q[$];    // expected writeback data
logic      jmp_q[$];    // expected jump flag
pc_t       jaddr_q[$];  // expected target, only looked at when taken

task automatic push_row(input string nm, input dec_grp_t grp, input dec_op_t op,
                        input logic imm_sel, input pc_t pc, input xlen_t imm,
                        input xlen_t rs1, input xlen_t rs2, input reg_addr_t rd,
                        input xlen_t res, input logic jmp, input pc_t jaddr);
    name_q.push_back(nm);
    grp_q.push_back(grp);
    op_q.push_back(op);
    imm_sel_q.push_back(imm_sel);
    pc_q.push_back(pc);
    imm_q.push_back(imm);
    rs1_q.push_back(rs1);
    rs2_q.push_back(rs2);
    rd_q.push_back(rd);
    res_q.push_back(res);
    jmp_q.push_back(jmp);
    jaddr_q.push_back(jaddr);
endtask

task automatic alu_row(input string nm, input dec_op_t op, input logic imm_sel,
                       input xlen_t imm, input xlen_t rs1, input xlen_t rs2,
                       input reg_addr_t rd, input xlen_t res);
    push_row(nm, DEC_GRP_ALU, op, imm_sel, '0, imm, rs1, rs2, rd, res, 1'b0, '0);
endtask

// branches and jumps, res only matters for jal and jalr
task automatic bjp_row(input string nm, input dec_op_t op, input pc_t pc, input xlen_t imm,
                       input xlen_t rs1, input xlen_t rs2, input reg_addr_t rd,
                       input xlen_t res, input logic jmp, input pc_t jaddr);
    push_row(nm, DEC_GRP_BJP, op, 1'b0, pc, imm, rs1, rs2, rd, res, jmp, jaddr);
endtask

task automatic md_row(input string nm, input dec_op_t op, input xlen_t rs1,
                      input xlen_t rs2, input reg_addr_t rd, input xlen_t res);
    push_row(nm, DEC_GRP_MULDIV, op, 1'b0, '0, '0, rs1, rs2, rd, res, 1'b0, '0);
endtask

task automatic build_table();
    alu_row("add", ALU_OP_ADD, 1'b0, 'h0, 'd5, 'd7, 5'd1, 'd12);
    alu_row("sub", ALU_OP_SUB, 1'b0, 'h0, 'd5, 'd7, 5'd2, 'hfffffffe);
    alu_row("and", ALU_OP_AND, 1'b0, 'h0, 'hf0f01234, 'h0ff0ffff, 5'd3, 'h00f01234);
    alu_row("or", ALU_OP_OR, 1'b0, 'h0, 'hf0000000, 'h0000000f, 5'd4, 'hf000000f);
    alu_row("xor", ALU_OP_XOR, 1'b0, 'h0, 'hffff0000, 'h0f0f0f0f, 5'd5, 'hf0f00f0f);
    alu_row("sll", ALU_OP_SLL, 1'b0, 'h0, 'h1, 'h24, 5'd6, 'h10);  // only 5 shift bits
    alu_row("srl", ALU_OP_SRL, 1'b0, 'h0, 'h80000000, 'h4, 5'd7, 'h08000000);
    alu_row("sra", ALU_OP_SRA, 1'b0, 'h0, 'h80000000, 'h4, 5'd8, 'hf8000000);
    alu_row("slt", ALU_OP_SLT, 1'b0, 'h0, 'hffffffff, 'h1, 5'd9, 'h1);
    alu_row("sltu", ALU_OP_SLTU, 1'b0, 'h0, 'hffffffff, 'h1, 5'd10, 'h0);
    alu_row("addi", ALU_OP_ADD, 1'b1, 'hfffffffc, 'h64, 'h1234, 5'd11, 'h60);
    alu_row("lui", ALU_OP_LUI, 1'b1, 'h12345000, 'hdead, 'h0, 5'd12, 'h12345000);
    bjp_row("beq_t", BJP_OP_BEQ, 'h1000, 'h10, 'd5, 'd5, 5'd0, 'h0, 1'b1, 'h1010);
    bjp_row("bne_nt", BJP_OP_BNE, 'h1000, 'h20, 'd5, 'd5, 5'd0, 'h0, 1'b0, 'h0);
    bjp_row("blt_t", BJP_OP_BLT, 'h2000, 'hfffffff0, 'hfffffffe, 'h1, 5'd0, 'h0, 1'b1, 'h1ff0);
    bjp_row("bge_nt", BJP_OP_BGE, 'h2000, 'hfffffff0, 'hfffffffe, 'h1, 5'd0, 'h0, 1'b0, 'h0);
    bjp_row("bltu_t", BJP_OP_BLTU, 'h3000, 'h8, 'h1, 'hfffffffe, 5'd0, 'h0, 1'b1, 'h3008);
    bjp_row("bgeu_t", BJP_OP_BGEU, 'h3000, 'hc, 'hfffffffe, 'h1, 5'd0, 'h0, 1'b1, 'h300c);
    bjp_row("jal", BJP_OP_JAL, 'h4000, 'h100, 'h0, 'h0, 5'd1, 'h4004, 1'b1, 'h4100);
    bjp_row("jalr", BJP_OP_JALR, 'h5000, 'h10, 'h8001, 'h0, 5'd2, 'h5004, 1'b1, 'h8010);
    md_row("mul", MD_OP_MUL, 'h7, 'hfffffffd, 5'd13, 'hffffffeb);
    md_row("mulh_min", MD_OP_MULH, 'h80000000, 'h80000000, 5'd14, 'h40000000);
    md_row("mulh_mix", MD_OP_MULH, 'hfffffffe, 'h3, 5'd15, 'hffffffff);
    md_row("mulhsu", MD_OP_MULHSU, 'hffffffff, 'hffffffff, 5'd16, 'hffffffff);
    md_row("mulhu", MD_OP_MULHU, 'hffffffff, 'hffffffff, 5'd17, 'hfffffffe);
    md_row("div", MD_OP_DIV, 'hffffffec, 'h3, 5'd18, 'hfffffffa);
    md_row("rem", MD_OP_REM, 'hffffffec, 'h3, 5'd19, 'hfffffffe);
    md_row("div_negdsr", MD_OP_DIV, 'd20, 'hfffffffd, 5'd20, 'hfffffffa);
    md_row("rem_negdsr", MD_OP_REM, 'd20, 'hfffffffd, 5'd21, 'h2);  // sign of dividend
    md_row("divu", MD_OP_DIVU, 'hffffffec, 'h3, 5'd22, 'h5555554e);
    md_row("remu", MD_OP_REMU, 'hffffffec, 'h3, 5'd23, 'h2);
    md_row("div_zero", MD_OP_DIV, 'h5, 'h0, 5'd24, 'hffffffff);
    md_row("divu_zero", MD_OP_DIVU, 'h5, 'h0, 5'd25, 'hffffffff);
    md_row("rem_zero", MD_OP_REM, 'hffffffec, 'h0, 5'd26, 'hffffffec);
    md_row("remu_zero", MD_OP_REMU, 'h7, 'h0, 5'd27, 'h7);
    md_row("div_ovf", MD_OP_DIV, 'h80000000, 'hffffffff, 5'd28, 'h80000000);
    md_row("rem_ovf", MD_OP_REM, 'h80000000, 'hffffffff, 5'd29, 'h0);
endtask

//--- bench/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    logic      clk_i;
    logic      rst_i;
    logic      issue_valid_i;
    dec_grp_t  grp_i;
    dec_op_t   op_i;
    logic      use_imm_i;
    pc_t       pc_i;
    xlen_t     imm_i;
    xlen_t     rs1_rdata_i;
    xlen_t     rs2_rdata_i;
    reg_addr_t rd_i;
    inst_id_t  inst_id_i;
    logic      alu_wb_ready_i;
    logic      muldiv_wb_ready_i;
    xlen_t     alu_wdata_o;
    logic      alu_we_o;
    reg_addr_t alu_waddr_o;
    inst_id_t  alu_commit_id_o;
    xlen_t     muldiv_wdata_o;
    logic      muldiv_we_o;
    reg_addr_t muldiv_waddr_o;
    inst_id_t  muldiv_commit_id_o;
    logic      stall_o;
    logic      jump_flag_o;
    pc_t       jump_addr_o;
    logic      muldiv_started_o;

    int          errors = 0;
    int          checks = 0;
    int          max_wait = 200;  // cycles per wait loop
    int unsigned seed_val;
    logic        timed_out = 1'b0;

    `include "exu_tb_cases.svh"

    exu dut_i (.*);

    always #5 clk_i = ~clk_i;

    task automatic check_equal(input string nm, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", nm, what, exp, act);
        end
    endtask

    // writeback back-pressure, ready about two thirds of the time
    task automatic randomize_ready();
        alu_wb_ready_i    = ($urandom % 3) != 0;
        muldiv_wb_ready_i = ($urandom % 3) != 0;
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what, input string nm);
        errors++;
        timed_out = 1'b1;
        $display("timeout in test %s: %s", nm, what);
    endtask

    // issue one row, check the jump outputs, then follow its writeback
    task automatic run_row(input int idx, input inst_id_t id);
        string nm;
        logic  to_alu;
        logic  to_md;
        logic  is_div;
        logic  we;
        logic  ready;
        logic  seen;
        logic  done;
        int    cycles;
        nm     = name_q[idx];
        to_md  = (grp_q[idx] == DEC_GRP_MULDIV);
        to_alu = (grp_q[idx] == DEC_GRP_ALU) || ((grp_q[idx] == DEC_GRP_BJP) &&
                 (op_q[idx] == BJP_OP_JAL || op_q[idx] == BJP_OP_JALR));
        is_div = to_md && op_q[idx][2];
        @(negedge clk_i);
        issue_valid_i = 1'b1;
        grp_i         = grp_q[idx];
        op_i          = op_q[idx];
        use_imm_i     = imm_sel_q[idx];
        pc_i          = pc_q[idx];
        imm_i         = imm_q[idx];
        rs1_rdata_i   = rs1_q[idx];
        rs2_rdata_i   = rs2_q[idx];
        rd_i          = rd_q[idx];
        inst_id_i     = id;
        randomize_ready();
        #1;
        cycles = 0;
        while (stall_o) begin  // hold the instruction
            if (cycles == max_wait) begin
                report_timeout("stall_o never released the issue", nm);
                return;
            end
            @(negedge clk_i);
            randomize_ready();
            #1;
            cycles++;
        end
        // accepted on the next rising edge
        check_equal(nm, "jump_flag_o", jmp_q[idx], jump_flag_o);
        if (jmp_q[idx]) begin
            check_equal(nm, "jump_addr_o", jaddr_q[idx], jump_addr_o);
        end
        check_equal(nm, "muldiv_started_o", to_md, muldiv_started_o);
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        randomize_ready();
        #1;
        check_equal(nm, "muldiv_started_o", 1'b0, muldiv_started_o);  // one pulse only
        cycles = 1;
        seen   = 1'b0;
        done   = !(to_alu || to_md);  // plain branches write nothing back
        while (!done) begin
            we    = to_md ? muldiv_we_o : alu_we_o;
            ready = to_md ? muldiv_wb_ready_i : alu_wb_ready_i;
            check_equal(nm, "we_o of the other channel", 1'b0,
                        to_md ? alu_we_o : muldiv_we_o);
            if (we) begin
                if (!seen && !is_div) begin
                    check_equal(nm, "latency", to_md ? 2 : 1, cycles);
                end
                seen = 1'b1;
                // held values are compared again on every waiting cycle
                check_equal(nm, "wdata", res_q[idx], to_md ? muldiv_wdata_o : alu_wdata_o);
                check_equal(nm, "waddr", rd_q[idx], to_md ? muldiv_waddr_o : alu_waddr_o);
                check_equal(nm, "commit_id", id,
                            to_md ? muldiv_commit_id_o : alu_commit_id_o);
                check_equal(nm, "stall_o", to_md | !ready, stall_o);
                done = ready;
            end else if (to_md) begin
                check_equal(nm, "stall_o", 1'b1, stall_o);  // busy until taken
            end
            if (!done) begin
                if (cycles == max_wait) begin
                    report_timeout("no writeback arrived", nm);
                    return;
                end
                @(negedge clk_i);
                randomize_ready();
                #1;
                cycles++;
            end
        end
        @(negedge clk_i);
        #1;
        check_equal(nm, "alu_we_o after writeback", 1'b0, alu_we_o);
        check_equal(nm, "muldiv_we_o after writeback", 1'b0, muldiv_we_o);
        check_equal(nm, "stall_o after writeback", 1'b0, stall_o);
    endtask

    initial begin
        seed_val          = $urandom(32'hb0e2_3e7c);
        clk_i             = 1'b0;
        rst_i             = 1'b1;
        issue_valid_i     = 1'b0;
        grp_i             = '0;
        op_i              = '0;
        use_imm_i         = 1'b0;
        pc_i              = '0;
        imm_i             = '0;
        rs1_rdata_i       = '0;
        rs2_rdata_i       = '0;
        rd_i              = '0;
        inst_id_i         = '0;
        alu_wb_ready_i    = 1'b0;
        muldiv_wb_ready_i = 1'b0;
        build_table();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        #1;
        check_equal("reset", "alu_we_o", 1'b0, alu_we_o);
        check_equal("reset", "muldiv_we_o", 1'b0, muldiv_we_o);
        check_equal("reset", "stall_o", 1'b0, stall_o);
        check_equal("reset", "jump_flag_o", 1'b0, jump_flag_o);
        check_equal("reset", "muldiv_started_o", 1'b0, muldiv_started_o);
        for (int i = 0; i < name_q.size() && !timed_out; i++) begin
            run_row(i, inst_id_t'(i));  // commit id wraps after 16 rows
        end
        finish_run();
    end

endmodule

//--- exu.f
+incdir+bench
logic/exu_pkg.sv
logic/exu_div.sv
logic/exu_dispatch.sv
logic/exu_alu.sv
logic/exu_bru.sv
logic/exu_muldiv.sv
logic/exu.sv
bench/exu_tb.sv

//--- logic/exu.sv
`timescale 1ns/1ps

module exu (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               issue_valid_i,
    input  exu_pkg::dec_grp_t  grp_i,
    input  exu_pkg::dec_op_t   op_i,
    input  logic               use_imm_i,
    input  exu_pkg::pc_t       pc_i,
    input  exu_pkg::xlen_t     imm_i,
    input  exu_pkg::xlen_t     rs1_rdata_i,
    input  exu_pkg::xlen_t     rs2_rdata_i,
    input  exu_pkg::reg_addr_t rd_i,
    input  exu_pkg::inst_id_t  inst_id_i,
    input  logic               alu_wb_ready_i,
    input  logic               muldiv_wb_ready_i,
    output exu_pkg::xlen_t     alu_wdata_o,
    output logic               alu_we_o,
    output exu_pkg::reg_addr_t alu_waddr_o,
    output exu_pkg::inst_id_t  alu_commit_id_o,
    output exu_pkg::xlen_t     muldiv_wdata_o,
    output logic               muldiv_we_o,
    output exu_pkg::reg_addr_t muldiv_waddr_o,
    output exu_pkg::inst_id_t  muldiv_commit_id_o,
    output logic               stall_o,
    output logic               jump_flag_o,
    output exu_pkg::pc_t       jump_addr_o,
    output logic               muldiv_started_o
);
    import exu_pkg::*;

    logic    alu_req;
    dec_op_t alu_op;
    xlen_t   alu_op1;
    xlen_t   alu_op2;
    logic    alu_stall;

    logic    bjp_req;
    dec_op_t bjp_op;
    xlen_t   bjp_op1;
    xlen_t   bjp_op2;
    pc_t     bjp_base;
    xlen_t   bjp_offset;

    logic    md_req;
    dec_op_t md_op;
    xlen_t   md_op1;
    xlen_t   md_op2;
    logic    md_busy;

    exu_dispatch u_dispatch (
        .issue_valid_i (issue_valid_i),
        .stall_i       (stall_o),
        .grp_i         (grp_i),
        .op_i          (op_i),
        .use_imm_i     (use_imm_i),
        .pc_i          (pc_i),
        .imm_i         (imm_i),
        .rs1_rdata_i   (rs1_rdata_i),
        .rs2_rdata_i   (rs2_rdata_i),
        .alu_req_o     (alu_req),
        .alu_op_o      (alu_op),
        .alu_op1_o     (alu_op1),
        .alu_op2_o     (alu_op2),
        .bjp_req_o     (bjp_req),
        .bjp_op_o      (bjp_op),
        .bjp_op1_o     (bjp_op1),
        .bjp_op2_o     (bjp_op2),
        .bjp_base_o    (bjp_base),
        .bjp_offset_o  (bjp_offset),
        .md_req_o      (md_req),
        .md_op_o       (md_op),
        .md_op1_o      (md_op1),
        .md_op2_o      (md_op2)
    );

    exu_alu u_alu (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (alu_req),
        .op_i        (alu_op),
        .op1_i       (alu_op1),
        .op2_i       (alu_op2),
        .rd_i        (rd_i),
        .inst_id_i   (inst_id_i),
        .wb_ready_i  (alu_wb_ready_i),
        .wdata_o     (alu_wdata_o),
        .we_o        (alu_we_o),
        .waddr_o     (alu_waddr_o),
        .commit_id_o (alu_commit_id_o),
        .stall_o     (alu_stall)
    );

    // resolves in the issue cycle
    exu_bru u_bru (
        .req_i       (bjp_req),
        .op_i        (bjp_op),
        .op1_i       (bjp_op1),
        .op2_i       (bjp_op2),
        .base_i      (bjp_base),
        .offset_i    (bjp_offset),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

    exu_muldiv u_muldiv (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (md_req),
        .op_i        (md_op),
        .op1_i       (md_op1),
        .op2_i       (md_op2),
        .rd_i        (rd_i),
        .inst_id_i   (inst_id_i),
        .wb_ready_i  (muldiv_wb_ready_i),
        .wdata_o     (muldiv_wdata_o),
        .we_o        (muldiv_we_o),
        .waddr_o     (muldiv_waddr_o),
        .commit_id_o (muldiv_commit_id_o),
        .busy_o      (md_busy),
        .started_o   (muldiv_started_o)
    );

    // hold issue on alu back-pressure or an unfinished mul/div
    assign stall_o = alu_stall | md_busy;

endmodule

//--- logic/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               req_i,
    input  exu_pkg::dec_op_t   op_i,
    input  exu_pkg::xlen_t     op1_i,
    input  exu_pkg::xlen_t     op2_i,
    input  exu_pkg::reg_addr_t rd_i,
    input  exu_pkg::inst_id_t  inst_id_i,
    input  logic               wb_ready_i,
    output exu_pkg::xlen_t     wdata_o,
    output logic               we_o,
    output exu_pkg::reg_addr_t waddr_o,
    output exu_pkg::inst_id_t  commit_id_o,
    output logic               stall_o
);
    import exu_pkg::*;

    xlen_t      result;
    logic [4:0] shamt;
    xlen_t      wdata_q;
    reg_addr_t  waddr_q;
    inst_id_t   id_q;
    logic       we_q;

    assign shamt = op2_i[4:0];

    always_comb begin
        case (op_i)
            ALU_OP_ADD:  result = op1_i + op2_i;
            ALU_OP_SUB:  result = op1_i - op2_i;
            ALU_OP_AND:  result = op1_i & op2_i;
            ALU_OP_OR:   result = op1_i | op2_i;
            ALU_OP_XOR:  result = op1_i ^ op2_i;
            ALU_OP_SLL:  result = op1_i << shamt;
            ALU_OP_SRL:  result = op1_i >> shamt;
            ALU_OP_SRA:  result = xlen_t'($signed(op1_i) >>> shamt);
            ALU_OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_OP_SLTU: result = {{(XLEN-1){1'b0}}, op1_i < op2_i};
            ALU_OP_LUI:  result = op2_i;
            default:     result = '0;
        endcase
    end

    // valid flag, a new request may replace a result consumed this cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            we_q <= 1'b0;
        end else if (req_i) begin
            we_q <= 1'b1;
        end else if (wb_ready_i) begin
            we_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            wdata_q <= result;
            waddr_q <= rd_i;
            id_q    <= inst_id_i;
        end
    end

    assign wdata_o     = wdata_q;
    assign we_o        = we_q;
    assign waddr_o     = waddr_q;
    assign commit_id_o = id_q;
    assign stall_o     = we_q & ~wb_ready_i;  // held and not taken

endmodule

//--- logic/exu_bru.sv
`timescale 1ns/1ps

module exu_bru (
    input  logic             req_i,
    input  exu_pkg::dec_op_t op_i,
    input  exu_pkg::xlen_t   op1_i,
    input  exu_pkg::xlen_t   op2_i,
    input  exu_pkg::pc_t     base_i,
    input  exu_pkg::xlen_t   offset_i,
    output logic             jump_flag_o,
    output exu_pkg::pc_t     jump_addr_o
);
    import exu_pkg::*;

    logic taken;
    logic lt_s;
    logic lt_u;
    pc_t  target;

    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (op_i)
            BJP_OP_BEQ:  taken = (op1_i == op2_i);
            BJP_OP_BNE:  taken = (op1_i != op2_i);
            BJP_OP_BLT:  taken = lt_s;
            BJP_OP_BGE:  taken = ~lt_s;
            BJP_OP_BLTU: taken = lt_u;
            BJP_OP_BGEU: taken = ~lt_u;
            BJP_OP_JAL,
            BJP_OP_JALR: taken = 1'b1;  // unconditional
            default:     taken = 1'b0;
        endcase
    end

    assign target = base_i + offset_i;

    assign jump_flag_o = req_i & taken;

    // jalr drops the low bit of the sum
    assign jump_addr_o = (op_i == BJP_OP_JALR) ? {target[31:1], 1'b0} : target;

endmodule

//--- logic/exu_dispatch.sv
`timescale 1ns/1ps

module exu_dispatch (
    input  logic               issue_valid_i,
    input  logic               stall_i,
    input  exu_pkg::dec_grp_t  grp_i,
    input  exu_pkg::dec_op_t   op_i,
    input  logic               use_imm_i,
    input  exu_pkg::pc_t       pc_i,
    input  exu_pkg::xlen_t     imm_i,
    input  exu_pkg::xlen_t     rs1_rdata_i,
    input  exu_pkg::xlen_t     rs2_rdata_i,

    // alu request
    output logic               alu_req_o,
    output exu_pkg::dec_op_t   alu_op_o,
    output exu_pkg::xlen_t     alu_op1_o,
    output exu_pkg::xlen_t     alu_op2_o,

    // branch unit request
    output logic               bjp_req_o,
    output exu_pkg::dec_op_t   bjp_op_o,
    output exu_pkg::xlen_t     bjp_op1_o,
    output exu_pkg::xlen_t     bjp_op2_o,
    output exu_pkg::pc_t       bjp_base_o,
    output exu_pkg::xlen_t     bjp_offset_o,

    // mul/div request
    output logic               md_req_o,
    output exu_pkg::dec_op_t   md_op_o,
    output exu_pkg::xlen_t     md_op1_o,
    output exu_pkg::xlen_t     md_op2_o
);
    import exu_pkg::*;

    logic accept;
    logic is_jump;
    logic is_jalr;

    // the only place where issue is qualified
    assign accept  = issue_valid_i & ~stall_i;
    assign is_jalr = (grp_i == DEC_GRP_BJP) && (op_i == BJP_OP_JALR);
    assign is_jump = is_jalr || ((grp_i == DEC_GRP_BJP) && (op_i == BJP_OP_JAL));

    // jumps also go to the alu for the link value
    assign alu_req_o = accept & ((grp_i == DEC_GRP_ALU) | is_jump);
    assign bjp_req_o = accept & (grp_i == DEC_GRP_BJP);
    assign md_req_o  = accept & (grp_i == DEC_GRP_MULDIV);

    // link address is pc + 4
    assign alu_op_o  = is_jump ? ALU_OP_ADD : op_i;
    assign alu_op1_o = is_jump ? pc_i : rs1_rdata_i;

    always_comb begin
        if (is_jump) begin
            alu_op2_o = 32'd4;
        end else if (use_imm_i) begin
            alu_op2_o = imm_i;
        end else begin
            alu_op2_o = rs2_rdata_i;
        end
    end

    assign bjp_op_o     = op_i;
    assign bjp_op1_o    = rs1_rdata_i;
    assign bjp_op2_o    = rs2_rdata_i;
    assign bjp_base_o   = is_jalr ? rs1_rdata_i : pc_i;  // jalr is register relative
    assign bjp_offset_o = imm_i;

    assign md_op_o  = op_i;
    assign md_op1_o = rs1_rdata_i;
    assign md_op2_o = rs2_rdata_i;

endmodule

//--- logic/exu_div.sv
`timescale 1ns/1ps

module exu_div (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           start_i,
    input  logic           signed_i,
    input  logic           rem_i,
    input  exu_pkg::xlen_t dividend_i,
    input  exu_pkg::xlen_t divisor_i,
    output exu_pkg::xlen_t result_o,
    output logic           valid_o
);
    import exu_pkg::*;

    div_state_t        state_q;
    logic [4:0]        cnt_q;
    xlen_t             quo_q;   // dividend bits shift out, quotient bits in
    xlen_t             rem_q;   // partial remainder
    xlen_t             dsr_q;   // divisor magnitude
    logic              neg_quo_q;
    logic              neg_rem_q;
    logic              rem_sel_q;
    logic              div_zero;
    xlen_t             a_mag;
    xlen_t             b_mag;
    logic [XLEN:0]     shifted;
    logic [XLEN+1:0]   trial;

    assign div_zero = (divisor_i == '0);
    assign a_mag    = (signed_i && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
    assign b_mag    = (signed_i && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;

    // one restoring step
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign trial   = {1'b0, shifted} - {2'b00, dsr_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (start_i) begin
                        state_q <= div_zero ? DONE : RUN;  // zero divisor skips the loop
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 5'd1;
                    if (cnt_q == 5'd31) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            dsr_q     <= b_mag;
            rem_sel_q <= rem_i;
            if (div_zero) begin
                quo_q     <= '1;
                rem_q     <= dividend_i;
                neg_quo_q <= 1'b0;
                neg_rem_q <= 1'b0;
            end else begin
                quo_q     <= a_mag;
                rem_q     <= '0;
                neg_quo_q <= signed_i & (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
                neg_rem_q <= signed_i & dividend_i[XLEN-1];
            end
        end else if (state_q == RUN) begin
            if (!trial[XLEN+1]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // min / -1 wraps back to min with these sign rules
    assign result_o = rem_sel_q ? (neg_rem_q ? -rem_q : rem_q)
                                : (neg_quo_q ? -quo_q : quo_q);
    assign valid_o  = (state_q == DONE);

endmodule

//--- logic/exu_muldiv.sv
`timescale 1ns/1ps

module exu_muldiv (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               req_i,
    input  exu_pkg::dec_op_t   op_i,
    input  exu_pkg::xlen_t     op1_i,
    input  exu_pkg::xlen_t     op2_i,
    input  exu_pkg::reg_addr_t rd_i,
    input  exu_pkg::inst_id_t  inst_id_i,
    input  logic               wb_ready_i,
    output exu_pkg::xlen_t     wdata_o,
    output logic               we_o,
    output exu_pkg::reg_addr_t waddr_o,
    output exu_pkg::inst_id_t  commit_id_o,
    output logic               busy_o,
    output logic               started_o
);
    import exu_pkg::*;

    logic                     is_div;
    logic                     a_signed;
    logic                     b_signed;
    logic signed [XLEN:0]     mul_a_q;  // sign or zero extended
    logic signed [XLEN:0]     mul_b_q;
    logic                     mul_hi_q;
    logic                     mul_v_q;
    logic signed [2*XLEN+1:0] product;
    xlen_t                    mul_res;
    xlen_t                    div_result;
    logic                     div_valid;
    xlen_t                    wdata_q;
    reg_addr_t                waddr_q;
    inst_id_t                 id_q;
    logic                     we_q;
    logic                     busy_q;

    assign is_div   = op_i[2];
    assign a_signed = (op_i != MD_OP_MULHU);
    assign b_signed = (op_i == MD_OP_MUL) || (op_i == MD_OP_MULH);

    // stage 1, operand capture
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            mul_a_q  <= {a_signed & op1_i[XLEN-1], op1_i};
            mul_b_q  <= {b_signed & op2_i[XLEN-1], op2_i};
            mul_hi_q <= (op_i != MD_OP_MUL);
        end
    end

    // stage 2 is the multiply itself, landing in the holding register
    assign product = mul_a_q * mul_b_q;
    assign mul_res = mul_hi_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

    exu_div u_div (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (req_i & is_div),
        .signed_i   (~op_i[0]),
        .rem_i      (op_i[1]),
        .dividend_i (op1_i),
        .divisor_i  (op2_i),
        .result_o   (div_result),
        .valid_o    (div_valid)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_v_q <= 1'b0;
            we_q    <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            mul_v_q <= req_i & ~is_div;
            if (mul_v_q || div_valid) begin
                we_q <= 1'b1;
            end else if (wb_ready_i) begin
                we_q <= 1'b0;
            end
            if (req_i) begin
                busy_q <= 1'b1;
            end else if (we_q && wb_ready_i) begin
                busy_q <= 1'b0;  // released once the result is taken
            end
        end
    end

    // result holding register
    always_ff @(posedge clk_i) begin
        if (mul_v_q) begin
            wdata_q <= mul_res;
        end else if (div_valid) begin
            wdata_q <= div_result;
        end
        if (req_i) begin
            waddr_q <= rd_i;
            id_q    <= inst_id_i;
        end
    end

    assign wdata_o     = wdata_q;
    assign we_o        = we_q;
    assign waddr_o     = waddr_q;
    assign commit_id_o = id_q;
    assign busy_o      = busy_q;
    assign started_o   = req_i;

endmodule

//--- logic/exu_pkg.sv
package exu_pkg;

    localparam int XLEN = 32;

    // widths with a meaning of their own
    typedef logic [XLEN-1:0] xlen_t;      // data and operands
    typedef logic [31:0]     pc_t;        // instruction address
    typedef logic [4:0]      reg_addr_t;  // destination register
    typedef logic [3:0]      inst_id_t;   // commit id, echoed with results
    typedef logic [1:0]      dec_grp_t;   // decode group
    typedef logic [3:0]      dec_op_t;    // operation inside a group

    // decode groups
    localparam dec_grp_t DEC_GRP_ALU    = 2'd0;
    localparam dec_grp_t DEC_GRP_BJP    = 2'd1;
    localparam dec_grp_t DEC_GRP_MULDIV = 2'd2;

    // alu operations
    localparam dec_op_t ALU_OP_ADD  = 4'd0;
    localparam dec_op_t ALU_OP_SUB  = 4'd1;
    localparam dec_op_t ALU_OP_AND  = 4'd2;
    localparam dec_op_t ALU_OP_OR   = 4'd3;
    localparam dec_op_t ALU_OP_XOR  = 4'd4;
    localparam dec_op_t ALU_OP_SLL  = 4'd5;
    localparam dec_op_t ALU_OP_SRL  = 4'd6;
    localparam dec_op_t ALU_OP_SRA  = 4'd7;
    localparam dec_op_t ALU_OP_SLT  = 4'd8;
    localparam dec_op_t ALU_OP_SLTU = 4'd9;
    localparam dec_op_t ALU_OP_LUI  = 4'd10;  // passes operand 2

    // branch and jump operations
    localparam dec_op_t BJP_OP_BEQ  = 4'd0;
    localparam dec_op_t BJP_OP_BNE  = 4'd1;
    localparam dec_op_t BJP_OP_BLT  = 4'd2;
    localparam dec_op_t BJP_OP_BGE  = 4'd3;
    localparam dec_op_t BJP_OP_BLTU = 4'd4;
    localparam dec_op_t BJP_OP_BGEU = 4'd5;
    localparam dec_op_t BJP_OP_JAL  = 4'd6;
    localparam dec_op_t BJP_OP_JALR = 4'd7;

    // M extension
    // bit 2 marks a divide, then bit 1 selects remainder and bit 0 unsigned
    localparam dec_op_t MD_OP_MUL    = 4'd0;
    localparam dec_op_t MD_OP_MULH   = 4'd1;
    localparam dec_op_t MD_OP_MULHSU = 4'd2;
    localparam dec_op_t MD_OP_MULHU  = 4'd3;
    localparam dec_op_t MD_OP_DIV    = 4'd4;
    localparam dec_op_t MD_OP_DIVU   = 4'd5;
    localparam dec_op_t MD_OP_REM    = 4'd6;
    localparam dec_op_t MD_OP_REMU   = 4'd7;

    // divider sequencing
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_t;

endpackage
